/* tdc_pkg.sv */
/* shared widths and the pulse FSM encoding for the ToT TDC core
   ToT is 12 bits, the accumulator carries one extra overflow bit */
package tdc_pkg;

    // ToT result and its accumulator, bit 12 marks overflow
    typedef logic [11:0] tdc_val_t;
    typedef logic [12:0] tdc_acc_t;

    // event numbering and external time reference
    typedef logic [15:0] event_cnt_t;
    typedef logic [15:0] timestamp_t;

    // {identifier, count or timestamp, ToT}
    typedef logic [31:0] fifo_word_t;

    // register bus
    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    typedef logic [7:0] lost_cnt_t; // saturates at 255

    // pulse finder states
    typedef enum logic [1:0] {
        TDC_IDLE  = 2'd0,
        TDC_ARMED = 2'd1,
        TDC_COUNT = 2'd2
    } tdc_state_t;

endpackage

/* tdc_arm_sync.sv */
/* arm_tdc is asynchronous and must stay high for at least two dv_clk cycles
   arm_pulse follows the rising edge of arm_tdc by 3 cycles */
module tdc_arm_sync (
    input  logic dv_clk,
    input  logic core_rst,
    input  logic arm_tdc,
    output logic arm_pulse
);

    logic [1:0] sync_q; // two-flop synchronizer
    logic       prev_q; // synchronized level one cycle back

    always_ff @(posedge dv_clk) begin
        if (core_rst) begin
            sync_q    <= 2'b00;
            prev_q    <= 1'b0;
            arm_pulse <= 1'b0;
        end else begin
            sync_q    <= {sync_q[0], arm_tdc};
            prev_q    <= sync_q[1];
            arm_pulse <= sync_q[1] & ~prev_q; // rising edge only
        end
    end

    // a level held high must not re-arm on the following cycle
    a_arm_single: assert property (
        @(posedge dv_clk) disable iff (core_rst)
        arm_pulse |=> !arm_pulse
    );

endmodule

/* tdc_pulse_fsm.sv */
/* one word of CLKDV*4 samples per cycle, bit 0 is the latest sample
   pulses must be separated by at least one word holding a 0 */
module tdc_pulse_fsm #(
    parameter int CLKDV = 4
) (
    input  logic                 dv_clk,
    input  logic                 core_rst,
    input  logic [CLKDV*4-1:0]   sample_word,
    input  logic                 tdc_enable,
    input  logic                 arm_mode,
    input  logic                 arm_pulse,
    output logic                 tdc_out,
    output logic                 start,
    output logic                 finish,
    output tdc_pkg::tdc_val_t    tdc_val
);

    localparam tdc_pkg::tdc_acc_t ACC_OVF = 13'h1000; // saturated overflow marker

    logic [CLKDV*4-1:0]  data_q;
    logic                one_seen;
    logic                zero_seen;
    logic                small_tot;
    logic                idle_live;
    logic                acc_ovf;
    tdc_pkg::tdc_acc_t   ones;
    tdc_pkg::tdc_acc_t   acc_q;
    tdc_pkg::tdc_acc_t   acc_sum;
    tdc_pkg::tdc_state_t state;
    tdc_pkg::tdc_state_t state_nxt;

    always_ff @(posedge dv_clk) begin
        if (core_rst) begin
            data_q <= '0;
        end else begin
            data_q <= sample_word;
        end
    end

    assign one_seen  = |data_q;
    assign zero_seen = ~&data_q;
    assign small_tot = one_seen & ~data_q[0]; // pulse already ended inside the word
    assign tdc_out   = one_seen;
    assign idle_live = tdc_enable & ~arm_mode; // free running mode

    always_comb begin : count_ones
        ones = '0;
        for (int i = 0; i < CLKDV * 4; i++) begin
            ones = ones + tdc_pkg::tdc_acc_t'(data_q[i]);
        end
    end

    always_ff @(posedge dv_clk) begin
        if (core_rst) begin
            state <= tdc_pkg::TDC_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        start     = 1'b0;
        finish    = 1'b0;
        case (state)
            tdc_pkg::TDC_IDLE: begin
                if (idle_live && one_seen && !small_tot) begin
                    state_nxt = tdc_pkg::TDC_COUNT;
                    start     = 1'b1;
                end else if (idle_live && small_tot) begin
                    finish = 1'b1; // single word pulse
                end else if (arm_pulse && tdc_enable && arm_mode) begin
                    state_nxt = tdc_pkg::TDC_ARMED;
                end
            end
            tdc_pkg::TDC_ARMED: begin
                if (one_seen && !small_tot) begin
                    state_nxt = tdc_pkg::TDC_COUNT;
                    start     = 1'b1;
                end else if (small_tot) begin
                    state_nxt = tdc_pkg::TDC_IDLE; // one shot, rearm needed
                    finish    = 1'b1;
                end else if (!tdc_enable) begin
                    state_nxt = tdc_pkg::TDC_IDLE;
                end
            end
            tdc_pkg::TDC_COUNT: begin
                if (zero_seen) begin
                    state_nxt = tdc_pkg::TDC_IDLE;
                    finish    = 1'b1;
                end else if (!tdc_enable) begin
                    state_nxt = tdc_pkg::TDC_IDLE; // abandoned, no result
                end
            end
            default: state_nxt = tdc_pkg::TDC_IDLE;
        endcase
    end

    assign acc_sum = acc_q + ones;
    assign acc_ovf = acc_q[12] | acc_sum[12];

    // start word loads the sum, each later count word adds to it
    always_ff @(posedge dv_clk) begin
        if (start) begin
            acc_q <= ones;
        end else if (state == tdc_pkg::TDC_COUNT) begin
            acc_q <= acc_ovf ? ACC_OVF : acc_sum;
        end
    end

    // outside count a finish is always a single word pulse
    assign tdc_val = (state != tdc_pkg::TDC_COUNT) ? ones[11:0] :
                     acc_ovf ? '0 : acc_sum[11:0];

    a_no_start_finish: assert property (
        @(posedge dv_clk) disable iff (core_rst)
        (state == tdc_pkg::TDC_IDLE && !small_tot) |-> !(start && finish)
    );

    a_state_legal: assert property (
        @(posedge dv_clk) disable iff (core_rst)
        state inside {tdc_pkg::TDC_IDLE, tdc_pkg::TDC_ARMED, tdc_pkg::TDC_COUNT}
    );

endmodule

/* tdc_event_packer.sv */
/* results finishing while the FIFO is full are dropped and counted
   the event count advances on every finish, written or not */
module tdc_event_packer #(
    parameter logic [3:0] DATA_IDENTIFIER = 4'b0100
) (
    input  logic                  dv_clk,
    input  logic                  core_rst,
    input  logic                  start,
    input  logic                  finish,
    input  tdc_pkg::tdc_val_t     tdc_val,
    input  tdc_pkg::timestamp_t   timestamp,
    input  logic                  write_ts,
    input  logic                  fifo_full,
    output logic                  fifo_wr,
    output tdc_pkg::fifo_word_t   fifo_wdata,
    output tdc_pkg::event_cnt_t   event_cnt,
    output tdc_pkg::lost_cnt_t    lost_cnt
);

    tdc_pkg::timestamp_t ts_q;
    tdc_pkg::timestamp_t ts_sel;
    logic                pulse_open; // a start was seen for the pending finish

    always_ff @(posedge dv_clk) begin
        if (start) begin
            ts_q <= timestamp;
        end
    end

    always_ff @(posedge dv_clk) begin
        if (core_rst) begin
            pulse_open <= 1'b0;
            event_cnt  <= '0;
            lost_cnt   <= '0;
        end else begin
            if (start) begin
                pulse_open <= 1'b1;
            end else if (finish) begin
                pulse_open <= 1'b0;
            end
            if (finish) begin
                event_cnt <= event_cnt + 1'b1;
            end
            if (finish && fifo_full && lost_cnt != '1) begin
                lost_cnt <= lost_cnt + 1'b1; // saturating
            end
        end
    end

    // single word pulse takes the timestamp of its finish cycle
    assign ts_sel     = pulse_open ? ts_q : timestamp;
    assign fifo_wr    = finish & ~fifo_full;
    assign fifo_wdata = {DATA_IDENTIFIER, (write_ts ? ts_sel : event_cnt), tdc_val};

    a_no_wr_full: assert property (
        @(posedge dv_clk) disable iff (core_rst)
        fifo_wr |-> !fifo_full
    );

endmodule

/* tdc_event_fifo.sv */
/* first-word-fall-through, fifo_data is valid while fifo_empty is low
   FIFO_DEPTH must be a power of two; reads when empty are ignored */
module tdc_event_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                dv_clk,
    input  logic                core_rst,
    input  logic                fifo_wr,
    input  tdc_pkg::fifo_word_t fifo_wdata,
    input  logic                fifo_read,
    output logic                fifo_full,
    output logic                fifo_empty,
    output tdc_pkg::fifo_word_t fifo_data
);

    localparam int AW = $clog2(FIFO_DEPTH);

    tdc_pkg::fifo_word_t mem [FIFO_DEPTH];
    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic [AW:0]         count;
    logic                do_wr;
    logic                do_rd;

    assign do_wr = fifo_wr & ~fifo_full;
    assign do_rd = fifo_read & ~fifo_empty;

    always_ff @(posedge dv_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= fifo_wdata;
        end
    end

    always_ff @(posedge dv_clk) begin
        if (core_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at depth
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign fifo_empty = (count == '0);
    assign fifo_full  = (count == (AW + 1)'(FIFO_DEPTH));
    assign fifo_data  = mem[rd_ptr]; // head word falls through

    a_wr_when_full: assert property (
        @(posedge dv_clk) disable iff (core_rst)
        fifo_full |-> !fifo_wr
    );

endmodule

/* tdc_regs.sv */
/* configuration survives the soft reset, counters and FIFO do not
   bus_data_out is valid one cycle after bus_rd */
module tdc_regs (
    input  logic                dv_clk,
    input  logic                rst_sync,
    input  tdc_pkg::bus_addr_t  bus_addr,
    input  tdc_pkg::bus_data_t  bus_data_in,
    input  logic                bus_wr,
    input  logic                bus_rd,
    input  logic                ext_en,
    input  tdc_pkg::event_cnt_t event_cnt,
    input  tdc_pkg::lost_cnt_t  lost_cnt,
    output tdc_pkg::bus_data_t  bus_data_out,
    output logic                core_rst,
    output logic                tdc_enable,
    output logic                arm_mode,
    output logic                write_ts
);

    tdc_pkg::bus_data_t  scratch;
    tdc_pkg::bus_data_t  conf;
    tdc_pkg::event_cnt_t event_snap; // taken on a read of address 3

    // soft reset from a write to address 0
    always_ff @(posedge dv_clk) begin
        core_rst <= rst_sync | (bus_wr && bus_addr == 16'd0);
    end

    always_ff @(posedge dv_clk) begin
        if (rst_sync) begin
            scratch <= '0;
            conf    <= '0;
        end else if (bus_wr) begin
            case (bus_addr)
                16'd0:   scratch <= bus_data_in;
                16'd1:   conf    <= bus_data_in;
                default: ;
            endcase
        end
    end

    always_ff @(posedge dv_clk) begin
        if (bus_rd) begin
            case (bus_addr)
                16'd0:   bus_data_out <= scratch;
                16'd1:   bus_data_out <= conf;
                16'd2:   bus_data_out <= lost_cnt;
                16'd3:   bus_data_out <= event_cnt[7:0];
                16'd4:   bus_data_out <= event_snap[15:8];
                default: bus_data_out <= '0;
            endcase
        end
    end

    // high byte stays consistent with the low byte just read
    always_ff @(posedge dv_clk) begin
        if (bus_rd && bus_addr == 16'd3) begin
            event_snap <= event_cnt;
        end
    end

    assign tdc_enable = conf[0] | (conf[3] & ext_en); // hardware gate option
    assign arm_mode   = conf[1];
    assign write_ts   = conf[2];

endmodule

/* tdc_core.sv */
/* single clock ToT TDC, the sample word arrives already deserialized
   result words are {DATA_IDENTIFIER, count or timestamp, ToT}, ToT 0 on overflow */
module tdc_core #(
    parameter int         CLKDV           = 4,
    parameter logic [3:0] DATA_IDENTIFIER = 4'b0100,
    parameter int         FIFO_DEPTH      = 16
) (
    input  logic                dv_clk,
    input  logic                rst_sync,
    input  logic [CLKDV*4-1:0]  sample_word,
    output logic                tdc_out,
    input  logic                arm_tdc,
    input  tdc_pkg::timestamp_t timestamp,
    input  logic                ext_en,
    input  logic                fifo_read,
    output logic                fifo_empty,
    output tdc_pkg::fifo_word_t fifo_data,
    input  tdc_pkg::bus_addr_t  bus_addr,
    input  tdc_pkg::bus_data_t  bus_data_in,
    input  logic                bus_wr,
    input  logic                bus_rd,
    output tdc_pkg::bus_data_t  bus_data_out
);

    logic                core_rst;
    logic                tdc_enable;
    logic                arm_mode;
    logic                write_ts;
    logic                arm_pulse;
    logic                start;
    logic                finish;
    tdc_pkg::tdc_val_t   tdc_val;
    logic                fifo_wr;
    logic                fifo_full;
    tdc_pkg::fifo_word_t fifo_wdata;
    tdc_pkg::event_cnt_t event_cnt;
    tdc_pkg::lost_cnt_t  lost_cnt;

    tdc_regs regs_inst (
        .dv_clk       (dv_clk),
        .rst_sync     (rst_sync),
        .bus_addr     (bus_addr),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .ext_en       (ext_en),
        .event_cnt    (event_cnt),
        .lost_cnt     (lost_cnt),
        .bus_data_out (bus_data_out),
        .core_rst     (core_rst),
        .tdc_enable   (tdc_enable),
        .arm_mode     (arm_mode),
        .write_ts     (write_ts)
    );

    tdc_arm_sync arm_sync_inst (
        .dv_clk    (dv_clk),
        .core_rst  (core_rst),
        .arm_tdc   (arm_tdc),
        .arm_pulse (arm_pulse)
    );

    tdc_pulse_fsm #(
        .CLKDV (CLKDV)
    ) pulse_fsm_inst (
        .dv_clk      (dv_clk),
        .core_rst    (core_rst),
        .sample_word (sample_word),
        .tdc_enable  (tdc_enable),
        .arm_mode    (arm_mode),
        .arm_pulse   (arm_pulse),
        .tdc_out     (tdc_out),
        .start       (start),
        .finish      (finish),
        .tdc_val     (tdc_val)
    );

    tdc_event_packer #(
        .DATA_IDENTIFIER (DATA_IDENTIFIER)
    ) packer_inst (
        .dv_clk     (dv_clk),
        .core_rst   (core_rst),
        .start      (start),
        .finish     (finish),
        .tdc_val    (tdc_val),
        .timestamp  (timestamp),
        .write_ts   (write_ts),
        .fifo_full  (fifo_full),
        .fifo_wr    (fifo_wr),
        .fifo_wdata (fifo_wdata),
        .event_cnt  (event_cnt),
        .lost_cnt   (lost_cnt)
    );

    tdc_event_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_inst (
        .dv_clk     (dv_clk),
        .core_rst   (core_rst),
        .fifo_wr    (fifo_wr),
        .fifo_wdata (fifo_wdata),
        .fifo_read  (fifo_read),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty),
        .fifo_data  (fifo_data)
    );

endmodule

/* tb_tdc_core.sv */
/* drives tdc_core with default parameters, 16 samples per word and a 16 deep FIFO
   expected words come from a reference model of the ToT rules */
module tb_tdc_core;

    localparam int         SAMPLE_W   = 16;
    localparam int         FIFO_DEPTH = 16;
    localparam logic [3:0] DATA_ID    = 4'b0100;
    localparam int         NO_WORD    = 0; // pulse ignored or left unchecked
    localparam int         LOST_WORD  = 1; // counted but dropped on a full FIFO
    localparam int         NEW_WORD   = 2;
    localparam int         TIMEOUT    = 400;

    logic                dv_clk;
    logic                rst_sync;
    logic [SAMPLE_W-1:0] sample_word;
    logic                tdc_out;
    logic                arm_tdc;
    tdc_pkg::timestamp_t timestamp;
    logic                ext_en;
    logic                fifo_read;
    logic                fifo_empty;
    tdc_pkg::fifo_word_t fifo_data;
    tdc_pkg::bus_addr_t  bus_addr;
    tdc_pkg::bus_data_t  bus_data_in;
    logic                bus_wr;
    logic                bus_rd;
    tdc_pkg::bus_data_t  bus_data_out;

    tdc_pkg::fifo_word_t exp_q[$];
    tdc_pkg::event_cnt_t exp_event; // next event number the core should use
    logic                ts_mode;
    logic                reader_on;
    logic [SAMPLE_W-1:0] last_word; // word captured on the latest edge
    integer              seed;
    int                  i;
    int                  off;
    int                  len;

    tdc_core tdc_core_inst (
        .dv_clk (dv_clk), .rst_sync (rst_sync), .sample_word (sample_word),
        .tdc_out (tdc_out), .arm_tdc (arm_tdc), .timestamp (timestamp), .ext_en (ext_en),
        .fifo_read (fifo_read), .fifo_empty (fifo_empty), .fifo_data (fifo_data),
        .bus_addr (bus_addr), .bus_data_in (bus_data_in), .bus_wr (bus_wr),
        .bus_rd (bus_rd), .bus_data_out (bus_data_out)
    );

    initial begin
        dv_clk = 1'b0;
        forever #5 dv_clk = ~dv_clk;
    end

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input tdc_pkg::fifo_word_t got, input tdc_pkg::fifo_word_t exp);
        if (got !== exp) begin
            $display("ERR %0t: result word got %h expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_byte(input tdc_pkg::bus_data_t got, input tdc_pkg::bus_data_t exp,
            input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // one cycle, inputs change 1 unit after the edge, timestamp moves every cycle
    task automatic tick();
        @(posedge dv_clk);
        #1;
        timestamp = timestamp + 16'd7;
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // sample j of word w is global sample w*16+j, bit 0 is the latest
    function automatic logic [SAMPLE_W-1:0] pulse_word(input int offset, input int len,
            input int w);
        logic [SAMPLE_W-1:0] word;
        int                  j;
        word = '0;
        for (j = 0; j < SAMPLE_W; j++) begin
            if (w * SAMPLE_W + j >= offset && w * SAMPLE_W + j < offset + len) begin
                word[SAMPLE_W - 1 - j] = 1'b1;
            end
        end
        return word;
    endfunction

    function automatic tdc_pkg::fifo_word_t expected_word(input int offset, input int len,
            input logic use_ts, input tdc_pkg::event_cnt_t event_no,
            input tdc_pkg::timestamp_t ts);
        logic [SAMPLE_W-1:0] word;
        tdc_pkg::tdc_val_t   tot;
        int                  acc;
        int                  w;
        int                  b;
        logic                done;
        acc  = 0;
        w    = 0;
        done = 1'b0;
        while (!done) begin
            word = pulse_word(offset, len, w);
            for (b = 0; b < SAMPLE_W; b++) begin
                if (word[b]) begin
                    acc++;
                end
            end
            // first word ends the pulse if its latest sample is low, later words on any 0
            done = (w == 0) ? !word[0] : (word != '1);
            w++;
        end
        tot = (acc > 4095) ? '0 : tdc_pkg::tdc_val_t'(acc); // overflow reads as 0
        return {DATA_ID, (use_ts ? ts : event_no), tot};
    endfunction

    // pulse words then three zero words, expected word queued one cycle in
    task automatic send_pulse(input int offset, input int len, input int outcome);
        int nw;
        int w;
        nw = (offset + len + SAMPLE_W - 1) / SAMPLE_W;
        for (w = 0; w < nw + 3; w++) begin
            tick();
            sample_word = pulse_word(offset, len, w);
            if (w == 1 && outcome != NO_WORD) begin
                if (outcome == NEW_WORD) begin
                    exp_q.push_back(expected_word(offset, len, ts_mode, exp_event, timestamp));
                end
                exp_event = exp_event + 16'd1;
            end
        end
    endtask

    task automatic bus_write(input tdc_pkg::bus_addr_t addr, input tdc_pkg::bus_data_t data);
        tick();
        bus_addr    = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        tick();
        bus_wr = 1'b0;
    endtask

    task automatic read_expect(input tdc_pkg::bus_addr_t addr, input tdc_pkg::bus_data_t exp,
            input string what);
        tick();
        bus_addr = addr;
        bus_rd   = 1'b1;
        tick();
        bus_rd = 1'b0;
        check_byte(bus_data_out, exp, what); // registered one cycle after bus_rd
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 || !fifo_empty) begin
            if (n == TIMEOUT) begin
                $display("timeout: %0d expected result words never left the FIFO", exp_q.size());
                abort_run();
            end
            tick();
            n++;
        end
    endtask

    // scoreboard, pops the head word whenever the FIFO shows one
    initial begin
        fifo_read = 1'b0;
        forever begin
            @(posedge dv_clk);
            #1;
            fifo_read = 1'b0;
            if (reader_on && !fifo_empty) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected result word %h at time %0t", fifo_data, $time);
                    abort_run();
                end
                check_word(fifo_data, exp_q.pop_front());
                fifo_read = 1'b1;
            end
        end
    end

    // tdc_out shows whether the word taken on the last edge held any 1
    initial begin
        last_word = '0;
        forever begin
            @(posedge dv_clk);
            last_word = sample_word;
            @(negedge dv_clk);
            if (!rst_sync) begin
                check_bit(tdc_out, |last_word, "tdc_out");
            end
        end
    end

    initial begin
        seed        = 99;
        rst_sync    = 1'b1;
        sample_word = '0;
        arm_tdc     = 1'b0;
        timestamp   = '0;
        ext_en      = 1'b0;
        bus_addr    = '0;
        bus_data_in = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        exp_event   = '0;
        ts_mode     = 1'b0;
        reader_on   = 1'b1;
        repeat (10) tick();
        rst_sync = 1'b0;
        repeat (3) tick();

        for (i = 0; i < 11; i++) begin // three with enable off, then eight recorded
            if (i == 3) begin
                bus_write(16'd1, 8'h01);
            end
            off = rand_below(16);
            len = 17 + rand_below(64);
            send_pulse(off, len, (i < 3) ? NO_WORD : NEW_WORD);
        end
        for (i = 0; i < 8; i++) begin // small ToT inside one word
            off = rand_below(14);
            len = 1 + rand_below(15 - off);
            send_pulse(off, len, NEW_WORD);
        end
        send_pulse(rand_below(16), 4100, NEW_WORD); // accumulator overflow
        send_pulse(rand_below(16), 4095, NEW_WORD);
        wait_drain();

        bus_write(16'd1, 8'h03); // arm mode
        send_pulse(5, 20, NO_WORD);
        tick();
        arm_tdc = 1'b1;
        repeat (3) tick();
        arm_tdc = 1'b0;
        repeat (6) tick();
        send_pulse(5, 20, NEW_WORD);
        send_pulse(2, 30, NO_WORD); // one shot, needs a new arm
        wait_drain();

        bus_write(16'd1, 8'h05); // timestamp field
        ts_mode = 1'b1;
        for (i = 0; i < 6; i++) begin
            off = rand_below(14);
            len = (i % 2 == 0) ? 17 + rand_below(40) : 1 + rand_below(15 - off);
            send_pulse(off, len, NEW_WORD);
        end
        wait_drain();

        bus_write(16'd1, 8'h01);
        ts_mode   = 1'b0;
        reader_on = 1'b0;
        repeat (2) tick();
        for (i = 0; i < FIFO_DEPTH + 3; i++) begin
            send_pulse(3, 9, (i < FIFO_DEPTH) ? NEW_WORD : LOST_WORD);
        end
        read_expect(16'd2, 8'd3, "lost count");
        read_expect(16'd3, exp_event[7:0], "event count low byte");
        read_expect(16'd4, exp_event[15:8], "event count high byte");
        reader_on = 1'b1;
        wait_drain();

        reader_on = 1'b0;
        repeat (2) tick();
        send_pulse(4, 6, NO_WORD); // stays in the FIFO until the soft reset
        send_pulse(1, 3, NO_WORD);
        bus_write(16'd0, 8'h5a);
        exp_event = '0;
        read_expect(16'd0, 8'h5a, "scratch");
        read_expect(16'd2, 8'd0, "lost count after soft reset");
        read_expect(16'd3, 8'd0, "event count low byte after soft reset");
        read_expect(16'd4, 8'd0, "event count high byte after soft reset");
        reader_on = 1'b1;
        repeat (5) tick();
        send_pulse(6, 8, NEW_WORD);
        wait_drain();
        repeat (10) tick();

        if (exp_q.size() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("run ended with %0d expected words not seen", exp_q.size());
            abort_run();
        end
    end

endmodule

/* list.f */
tdc_pkg.sv
tdc_arm_sync.sv
tdc_pulse_fsm.sv
tdc_event_packer.sv
tdc_event_fifo.sv
tdc_regs.sv
tdc_core.sv
tb_tdc_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the ToT TDC testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_tdc_core
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
